// File: src/stack_core_pkg.sv
package stack_core_pkg;

  typedef enum logic [2:0] {
    SRCA_STK0,
    SRCA_STK1,
    SRCA_FP,
    SRCA_IP,
    SRCA_CSTK
  } src_a_e;

  typedef enum logic [1:0] {
    SRC_IMM,
    SRC_STK1,
    SRC_ISR
  } src_b_e;

  typedef enum logic [5:0] {
    ALU_ADD   = 6'd0,
    ALU_SUB   = 6'd1,
    ALU_AND   = 6'd2,
    ALU_OR    = 6'd3,
    ALU_XOR   = 6'd4,
    ALU_A     = 6'd8,
    ALU_B     = 6'd9,
    ALU_ADDZ  = 6'd16,
    ALU_ADDNZ = 6'd17
  } alu_op_e;

  typedef struct packed {
    logic [15:0] imm;    // Already masked and extended
    src_a_e      src_a;
    src_b_e      src_b;
    alu_op_e     alu_sel;
    logic        wr_stk1;
    logic        pop;
    logic        push;
    logic        load_stk;
    logic        load_fp;
    logic        load_ip;
    logic        load_isr;
    logic        cpop;
    logic        cpush;
    logic        byt;
    logic        rd_mem;
    logic        wr_mem;
    logic        set_ien;
  } decoded_t;

  typedef struct packed {
    logic [15:0] ip;     // Address of the retired instruction
    logic [15:0] stk0;
    logic [15:0] fp;
    logic        redirect;
    logic [15:0] target;
  } retire_t;

endpackage

// File: src/insn_buffer.sv
`timescale 1ns/10ps

module insn_buffer (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid,
  output logic        in_ready,
  input  logic [15:0] in_insn,
  output logic        out_valid,
  input  logic        out_ready,
  output logic [15:0] out_insn
);

  logic        skid_valid;
  logic [15:0] skid_insn;
  logic        out_free;

  assign in_ready = ~skid_valid;             // Registered, no path from out_ready
  assign out_free = out_ready | ~out_valid;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end
    else if (out_free)
    begin
      out_valid  <= skid_valid | in_valid;
      skid_valid <= 1'b0;
    end
    else if (in_valid && in_ready)
    begin
      skid_valid <= 1'b1;                    // Output stalled, park it
    end
  end

  always_ff @(posedge clk)
  begin
    if (out_free)
    begin
      if (skid_valid)
        out_insn <= skid_insn;
      else if (in_valid)
        out_insn <= in_insn;
    end
    else if (in_valid && in_ready)
    begin
      skid_insn <= in_insn;
    end
  end

  hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_insn))
    else $error("insn_buffer: output changed while stalled");

endmodule

// File: src/decoder.sv
`timescale 1ns/10ps

module decoder (
  input  logic [15:0]              insn,
  output stack_core_pkg::decoded_t dec
);

  logic        sign;
  logic [15:0] imm_mask;

  function automatic logic calc_sign(input logic [15:0] ins);
    casez (ins)
      16'b000?_????_????_????: return ins[11];
      default:                 return 1'b0;
    endcase
  endfunction

  function automatic logic [15:0] calc_imm_mask(input logic [3:0] op);
    casez (op)
      4'b1???: return 16'h7fff;
      4'b000?: return 16'h0ffe;
      4'b0100: return 16'h03fe;
      default: return 16'h03ff;
    endcase
  endfunction

  function automatic stack_core_pkg::src_a_e calc_src_a(input logic [15:0] ins);
    casez (ins)
      16'b000?_????_????_????: return stack_core_pkg::SRCA_IP;     // Relative jumps
      16'b001?_????_????_????: return stack_core_pkg::src_a_e'({1'b0, ins[11:10]});
      16'b010?_????_????_????: return stack_core_pkg::src_a_e'({1'b0, ins[11:10]});
      16'b0110_01??_????_????: return stack_core_pkg::SRCA_FP;
      16'b0111_1???_???1_??1?: return stack_core_pkg::SRCA_CSTK;   // Interrupt return
      16'b0111_1???_???1_???0: return stack_core_pkg::SRCA_IP;
      16'b0111_1???_????_00?0: return stack_core_pkg::SRCA_CSTK;
      16'b0111_1???_????_0011: return stack_core_pkg::SRCA_FP;
      default:                 return stack_core_pkg::SRCA_STK0;
    endcase
  endfunction

  function automatic stack_core_pkg::src_b_e calc_src_b(input logic [15:0] ins);
    casez (ins)
      16'b0111_1???_???1_????: return stack_core_pkg::SRC_ISR;
      16'b0111_????_????_????: return stack_core_pkg::SRC_STK1;
      default:                 return stack_core_pkg::SRC_IMM;
    endcase
  endfunction

  function automatic stack_core_pkg::alu_op_e calc_alu_sel(input logic [15:0] ins);
    casez (ins)
      16'b1???_????_????_????: return stack_core_pkg::ALU_B;
      16'b0001_????_????_???0: return stack_core_pkg::ALU_ADDZ;
      16'b0001_????_????_???1: return stack_core_pkg::ALU_ADDNZ;
      16'b001?_00??_????_????: return stack_core_pkg::ALU_B;       // Absolute address
      16'b010?_00??_????_????: return stack_core_pkg::ALU_B;
      16'b0110_00??_????_????: return stack_core_pkg::ALU_B;
      16'b0111_0???_????_????: return stack_core_pkg::alu_op_e'(ins[5:0]);
      16'b0111_1???_???1_??00: return stack_core_pkg::ALU_B;
      16'b0111_1???_????_????: return stack_core_pkg::ALU_A;
      default:                 return stack_core_pkg::ALU_ADD;
    endcase
  endfunction

  function automatic logic calc_pop(input logic [15:0] ins);
    casez (ins)
      16'b0001_????_????_????: return 1'b1;
      16'b0011_????_????_????: return 1'b1;
      16'b0100_????_????_???1: return 1'b1;
      16'b0111_0???_?1??_????: return 1'b1;                        // ALU pop bit
      16'b0111_1???_????_?1??: return 1'b1;
      16'b0111_1???_???1_???1: return 1'b1;
      default:                 return 1'b0;
    endcase
  endfunction

  function automatic logic calc_push(input logic [15:0] ins);
    casez (ins)
      16'b1???_????_????_????: return 1'b1;
      16'b0010_????_????_????: return 1'b1;
      16'b0100_????_????_???0: return 1'b1;
      16'b0101_????_????_????: return 1'b1;
      16'b0111_????_1???_????: return 1'b1;                        // ALU push bit
      default:                 return 1'b0;
    endcase
  endfunction

  function automatic logic calc_load_stk(input logic [15:0] ins);
    casez (ins)
      16'b0111_0???_????_????: return 1'b1;
      16'b0111_1???_????_1?0?: return 1'b1;
      default:                 return calc_push(ins);
    endcase
  endfunction

  function automatic logic calc_load_fp(input logic [15:0] ins);
    casez (ins)
      16'b0110_01??_????_????: return 1'b1;
      16'b0111_1???_???0_0010: return 1'b1;
      default:                 return 1'b0;
    endcase
  endfunction

  function automatic logic calc_load_ip(input logic [15:0] ins);
    casez (ins)
      16'b000?_????_????_????: return 1'b1;
      16'b0110_00??_????_????: return 1'b1;
      16'b0111_1???_????_0000: return 1'b1;
      16'b0111_1???_???1_0010: return 1'b1;
      default:                 return 1'b0;
    endcase
  endfunction

  function automatic logic calc_cpop(input logic [15:0] ins);
    casez (ins)
      16'b0111_1???_???0_00?0: return 1'b1;
      16'b0111_1???_???1_??1?: return 1'b1;
      default:                 return 1'b0;
    endcase
  endfunction

  function automatic logic calc_cpush(input logic [15:0] ins);
    casez (ins)
      16'b0000_????_????_???1: return 1'b1;                        // Call
      16'b0110_00??_????_????: return 1'b1;
      16'b0111_1???_???1_??00: return 1'b1;
      16'b0111_1???_????_0011: return 1'b1;
      default:                 return 1'b0;
    endcase
  endfunction

  function automatic logic calc_byt(input logic [15:0] ins);
    casez (ins)
      16'b001?_????_????_????: return 1'b1;
      16'b0111_????_????_???1: return 1'b1;
      default:                 return 1'b0;
    endcase
  endfunction

  function automatic logic calc_rd_mem(input logic [15:0] ins);
    casez (ins)
      16'b0010_????_????_????: return 1'b1;
      16'b0100_????_????_???0: return 1'b1;
      16'b0110_00??_????_????: return 1'b1;                        // Indirect call
      16'b0111_1???_????_10??: return 1'b1;
      default:                 return 1'b0;
    endcase
  endfunction

  function automatic logic calc_wr_mem(input logic [15:0] ins);
    casez (ins)
      16'b0011_????_????_????: return 1'b1;
      16'b0100_????_????_???1: return 1'b1;
      16'b0111_1???_????_11??: return 1'b1;
      default:                 return 1'b0;
    endcase
  endfunction

  assign sign     = calc_sign(insn);
  assign imm_mask = calc_imm_mask(insn[15:12]);

  always_comb
  begin
    dec.imm      = (insn & imm_mask) | (sign ? ~imm_mask : 16'h0000);
    dec.src_a    = calc_src_a(insn);
    dec.src_b    = calc_src_b(insn);
    dec.alu_sel  = calc_alu_sel(insn);
    dec.wr_stk1  = (calc_src_b(insn) == stack_core_pkg::SRC_STK1) & insn[3];
    dec.pop      = calc_pop(insn);
    dec.push     = calc_push(insn);
    dec.load_stk = calc_load_stk(insn);
    dec.load_fp  = calc_load_fp(insn);
    dec.load_ip  = calc_load_ip(insn);
    dec.load_isr = (insn == 16'h7811);
    dec.cpop     = calc_cpop(insn);
    dec.cpush    = calc_cpush(insn);
    dec.byt      = calc_byt(insn);
    dec.rd_mem   = calc_rd_mem(insn);
    dec.wr_mem   = calc_wr_mem(insn);
    dec.set_ien  = (insn == 16'h7812);
  end

endmodule

// File: src/alu.sv
`timescale 1ns/10ps

module alu (
  input  logic                    [15:0] a,
  input  logic                    [15:0] b,
  input  stack_core_pkg::alu_op_e        op,
  input  logic                           zero_in,
  output logic                    [15:0] result,
  output logic                           take
);

  always_comb
  begin
    take = 1'b1;                         // Unconditional unless a branch op
    case (op)
      stack_core_pkg::ALU_ADD:   result = a + b;
      stack_core_pkg::ALU_SUB:   result = a - b;
      stack_core_pkg::ALU_AND:   result = a & b;
      stack_core_pkg::ALU_OR:    result = a | b;
      stack_core_pkg::ALU_XOR:   result = a ^ b;
      stack_core_pkg::ALU_A:     result = a;
      stack_core_pkg::ALU_B:     result = b;
      stack_core_pkg::ALU_ADDZ:
      begin
        result = a + b;
        take   = zero_in;
      end
      stack_core_pkg::ALU_ADDNZ:
      begin
        result = a + b;
        take   = ~zero_in;
      end
      default:                   result = a;
    endcase
  end

endmodule

// File: src/lifo_stack.sv
`timescale 1ns/10ps

module lifo_stack #(
  parameter int DEPTH = 16
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        push,
  input  logic        pop,
  input  logic        load_top,
  input  logic        wr_second,
  input  logic [15:0] din,
  output logic [15:0] top,
  output logic [15:0] second,
  output logic        overflow
);

  localparam int CW = $clog2(DEPTH + 1);
  localparam int AW = $clog2(DEPTH - 2);

  logic [15:0]   spill [DEPTH-2];
  logic [CW-1:0] cnt;                   // Entries held, registers included
  logic          do_push;
  logic          do_pop;
  logic [AW-1:0] wr_idx;
  logic [AW-1:0] rd_idx;

  assign do_push  = push & ~pop;
  assign do_pop   = pop & ~push;
  assign overflow = do_push & (cnt == CW'(DEPTH));
  assign wr_idx   = AW'(cnt - CW'(2));
  assign rd_idx   = AW'(cnt - CW'(3));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      top    <= 16'h0000;
      second <= 16'h0000;
      cnt    <= '0;
    end
    else if (do_push)
    begin
      top    <= load_top ? din : top;
      second <= top;
      if (!overflow)
        cnt <= cnt + 1'b1;
    end
    else if (do_pop)
    begin
      top    <= load_top ? din : second;
      second <= (cnt > CW'(2)) ? spill[rd_idx] : 16'h0000;
      if (cnt != '0)
        cnt <= cnt - 1'b1;
    end
    else
    begin
      if (load_top)
        top <= din;
      if (wr_second)
        second <= top;                  // Swap when paired with load_top
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push && cnt >= CW'(2) && !overflow)
      spill[wr_idx] <= second;
  end

  pop_empty_a: assert property (@(posedge clk) disable iff (!rst_n)
    do_pop |-> cnt != '0)
    else $error("lifo_stack: pop on empty stack");

endmodule

// File: src/execute_stage.sv
`timescale 1ns/10ps

module execute_stage #(
  parameter int STK_DEPTH = 16,
  parameter int MEM_BYTES = 128
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  stack_core_pkg::decoded_t dec,
  output logic                     retire_valid,
  input  logic                     retire_ready,
  output stack_core_pkg::retire_t  retire
);

  localparam int AW = $clog2(MEM_BYTES);

  logic [7:0]    mem [MEM_BYTES];
  logic [15:0]   ip;
  logic [15:0]   fp;
  logic [15:0]   isr;
  logic [15:0]   stk0;
  logic [15:0]   stk1;
  logic [15:0]   ctop;
  logic [15:0]   a;
  logic [15:0]   b;
  logic [15:0]   result;
  logic [15:0]   mem_rdata;
  logic [15:0]   value;
  logic [15:0]   ip_inc;
  logic [15:0]   ip_next;
  logic [15:0]   fp_next;
  logic [15:0]   stk0_next;
  logic [15:0]   cstk_din;
  logic [AW-1:0] addr;
  logic [AW-1:0] addr_hi;
  logic          take;
  logic          jump;
  logic          fire;
  logic          dstk_ovf;
  logic          cstk_ovf;

  assign in_ready = retire_ready | ~retire_valid;
  assign fire     = in_valid & in_ready;

  always_comb
  begin
    case (dec.src_a)
      stack_core_pkg::SRCA_STK1: a = stk1;
      stack_core_pkg::SRCA_FP:   a = fp;
      stack_core_pkg::SRCA_IP:   a = ip;
      stack_core_pkg::SRCA_CSTK: a = ctop;
      default:                   a = stk0;
    endcase
    case (dec.src_b)
      stack_core_pkg::SRC_STK1:  b = stk1;
      stack_core_pkg::SRC_ISR:   b = isr;
      default:                   b = dec.imm;
    endcase
  end

  alu u_alu (
    .a       (a),
    .b       (b),
    .op      (dec.alu_sel),
    .zero_in (stk0 == 16'h0000),
    .result  (result),
    .take    (take)
  );

  // Little-endian words, address comes straight from the ALU
  assign addr      = result[AW-1:0];
  assign addr_hi   = AW'(addr + 1'b1);
  assign mem_rdata = dec.byt ? {8'h00, mem[addr]} : {mem[addr_hi], mem[addr]};
  assign value     = dec.rd_mem ? mem_rdata : result;

  assign ip_inc    = ip + 16'd2;
  assign jump      = dec.load_ip & take;
  assign ip_next   = jump ? value : ip_inc;
  assign fp_next   = dec.load_fp ? value : fp;
  assign stk0_next = dec.load_stk ? value : ((dec.pop & ~dec.push) ? stk1 : stk0);
  assign cstk_din  = (dec.src_a == stack_core_pkg::SRCA_FP) ? fp : ip_inc;

  lifo_stack #(.DEPTH(STK_DEPTH)) u_dstk (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (fire & dec.push),
    .pop       (fire & dec.pop),
    .load_top  (fire & dec.load_stk),
    .wr_second (fire & dec.wr_stk1),
    .din       (value),
    .top       (stk0),
    .second    (stk1),
    .overflow  (dstk_ovf)
  );

  lifo_stack #(.DEPTH(STK_DEPTH)) u_cstk (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (fire & dec.cpush),
    .pop       (fire & dec.cpop),
    .load_top  (fire & dec.cpush),
    .wr_second (1'b0),
    .din       (cstk_din),
    .top       (ctop),
    .second    (),
    .overflow  (cstk_ovf)
  );

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ip           <= 16'h0000;
      fp           <= 16'h0000;
      isr          <= 16'h0000;
      retire_valid <= 1'b0;
    end
    else
    begin
      if (fire)
      begin
        ip <= ip_next;
        fp <= fp_next;
        if (dec.load_isr)
          isr <= value;
      end
      if (fire)
        retire_valid <= 1'b1;
      else if (retire_ready)
        retire_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fire)
    begin
      retire <= '{ip: ip, stk0: stk0_next, fp: fp_next, redirect: jump, target: ip_next};
    end
    if (fire && dec.wr_mem)
    begin
      mem[addr] <= stk1[7:0];
      if (!dec.byt)
        mem[addr_hi] <= stk1[15:8];
    end
  end

  stk_ovf_a: assert property (@(posedge clk) disable iff (!rst_n)
    !(dstk_ovf || cstk_ovf))
    else $error("execute_stage: stack overflow");

endmodule

// File: src/stack_core.sv
`timescale 1ns/10ps

module stack_core #(
  parameter int STK_DEPTH = 16,
  parameter int MEM_BYTES = 128
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    insn_valid,
  output logic                    insn_ready,
  input  logic [15:0]             insn,
  output logic                    retire_valid,
  input  logic                    retire_ready,
  output stack_core_pkg::retire_t retire
);

  logic                     buf_valid;
  logic                     buf_ready;
  logic [15:0]              buf_insn;
  stack_core_pkg::decoded_t dec;

  insn_buffer u_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (insn_valid),
    .in_ready  (insn_ready),
    .in_insn   (insn),
    .out_valid (buf_valid),
    .out_ready (buf_ready),
    .out_insn  (buf_insn)
  );

  decoder u_dec (
    .insn (buf_insn),
    .dec  (dec)
  );

  execute_stage #(
    .STK_DEPTH (STK_DEPTH),
    .MEM_BYTES (MEM_BYTES)
  ) u_exe (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (buf_valid),
    .in_ready     (buf_ready),
    .dec          (dec),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire       (retire)
  );

endmodule

// File: verification/stack_core_tb.sv
`timescale 1ns/10ps

module stack_core_tb;

  localparam int TIMEOUT  = 200;
  localparam int MAX_PROG = 64;

  logic                    clk;
  logic                    rst_n;
  logic                    insn_valid;
  logic                    insn_ready;
  logic [15:0]             insn;
  logic                    retire_valid;
  logic                    retire_ready;
  stack_core_pkg::retire_t retire;

  logic [31:0]             lfsr_state = 32'h47c7_4923;
  int                      errors = 0;
  int                      retired = 0;
  int                      n_prog = 0;
  logic [15:0]             prog [MAX_PROG];
  stack_core_pkg::retire_t exp_arr [MAX_PROG];
  stack_core_pkg::retire_t exp_cur;
  stack_core_pkg::retire_t last_retire;

  // Reference model state
  logic [15:0]             model_ip = 16'h0000;
  logic [15:0]             model_stk [$];
  logic [7:0]              model_mem [int];

  stack_core #(
    .STK_DEPTH (16),
    .MEM_BYTES (128)
  ) dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .insn_valid   (insn_valid),
    .insn_ready   (insn_ready),
    .insn         (insn),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire       (retire)
  );

  always #2 clk = ~clk;

  function automatic logic [32-1:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  always @(posedge clk)
  begin
    lfsr_state = lfsr_step(lfsr_state);
    retire_ready <= lfsr_state[0];       // Random stalls at one bit per step
    last_retire  <= retire;
    if (rst_n && retire_valid && retire_ready)
      retired <= retired + 1;
  end

  assign exp_cur = (retired < MAX_PROG) ? exp_arr[retired] : '0;

  function automatic logic [15:0] stack_top();
    return (model_stk.size() > 0) ? model_stk[$] : 16'h0000;
  endfunction

  function automatic logic [15:0] pop_model();
    if (model_stk.size() == 0)
      return 16'h0000;
    return model_stk.pop_back();
  endfunction

  // Bit 0 lies outside the jump mask and fills with the sign
  function automatic logic [15:0] rel_offset(input logic [11:0] off);
    return {{4{off[11]}}, off[11:1], off[11]};
  endfunction

  task automatic record_step(input logic [15:0] word, input logic taken,
                             input logic [15:0] dest);
    logic [15:0] next_ip;
    next_ip = taken ? dest : model_ip + 16'd2;
    prog[n_prog]    = word;
    exp_arr[n_prog] = '{ip: model_ip, stk0: stack_top(), fp: 16'h0000,
                        redirect: taken, target: next_ip};
    model_ip = next_ip;
    n_prog++;
  endtask

  task automatic push_imm(input logic [14:0] v);
    model_stk.push_back({1'b0, v});
    record_step({1'b1, v}, 1'b0, 16'h0000);
  endtask

  task automatic alu_insn(input stack_core_pkg::alu_op_e op);
    logic [15:0] t;
    logic [15:0] s;
    logic [15:0] r;
    t = pop_model();
    s = pop_model();
    case (op)
      stack_core_pkg::ALU_ADD: r = t + s;
      stack_core_pkg::ALU_SUB: r = t - s;
      stack_core_pkg::ALU_AND: r = t & s;
      stack_core_pkg::ALU_OR:  r = t | s;
      default:                 r = t ^ s;
    endcase
    model_stk.push_back(r);
    record_step(16'h7040 | 16'(op), 1'b0, 16'h0000);   // Pop form leaves the result on top
  endtask

  task automatic store_word(input logic [9:0] addr);
    logic [15:0] v;
    v = (model_stk.size() > 1) ? model_stk[model_stk.size() - 2] : 16'h0000;
    model_mem[int'(addr)]     = v[7:0];
    model_mem[int'(addr) + 1] = v[15:8];
    void'(pop_model());
    record_step(16'h4001 | {6'h00, addr}, 1'b0, 16'h0000);
  endtask

  task automatic load_word(input logic [9:0] addr);
    model_stk.push_back({model_mem[int'(addr) + 1], model_mem[int'(addr)]});
    record_step(16'h4000 | {6'h00, addr}, 1'b0, 16'h0000);
  endtask

  task automatic load_byte(input logic [9:0] addr);
    model_stk.push_back({8'h00, model_mem[int'(addr)]});
    record_step(16'h2000 | {6'h00, addr}, 1'b0, 16'h0000);
  endtask

  task automatic jump_rel(input logic [11:0] off);
    record_step({4'h0, off[11:1], 1'b0}, 1'b1, model_ip + rel_offset(off));
  endtask

  task automatic branch_rel(input logic nz, input logic [11:0] off);
    logic [15:0] t;
    logic        taken;
    t     = pop_model();
    taken = nz ? (t != 16'h0000) : (t == 16'h0000);
    record_step({4'h1, off[11:1], nz}, taken, model_ip + rel_offset(off));
  endtask

  task automatic build_program();
    push_imm(15'h1234);
    push_imm(15'h7fff);
    alu_insn(stack_core_pkg::ALU_ADD);
    push_imm(15'h0fff);
    alu_insn(stack_core_pkg::ALU_SUB);
    push_imm(15'h3c3c);
    alu_insn(stack_core_pkg::ALU_AND);
    push_imm(15'h4001);
    alu_insn(stack_core_pkg::ALU_OR);
    push_imm(15'h5555);
    alu_insn(stack_core_pkg::ALU_XOR);
    push_imm(15'h4321);
    push_imm(15'h4321);
    alu_insn(stack_core_pkg::ALU_ADD);   // Sum 8642 has the high bit set
    push_imm(15'h0001);
    store_word(10'h020);
    load_word(10'h020);
    load_byte(10'h020);
    load_byte(10'h021);
    jump_rel(12'h010);
    jump_rel(-12'sd8);                   // Sign-extended offset
    push_imm(15'h0000);
    branch_rel(1'b0, 12'h00c);
    push_imm(15'h0005);
    branch_rel(1'b0, 12'h00c);           // Not taken
    push_imm(15'h0005);
    branch_rel(1'b1, -12'sd20);
    push_imm(15'h0000);
    branch_rel(1'b1, 12'h004);           // Not taken
    push_imm(15'h0002);
    alu_insn(stack_core_pkg::ALU_ADD);
  endtask

  task automatic send_insn(input logic [15:0] word, output logic ok);
    int waited;
    waited = 0;
    insn_valid <= 1'b1;
    insn       <= word;
    @(posedge clk);
    while (!insn_ready && waited < TIMEOUT)
    begin
      @(posedge clk);
      waited++;
    end
    ok = insn_ready;
  endtask

  property field_ok(logic [15:0] got, logic [15:0] want);
    @(posedge clk) disable iff (!rst_n)
      retire_valid && retire_ready |-> got == want;
  endproperty

  reset_a: assert property (@(posedge clk) $rose(rst_n) |-> !retire_valid && insn_ready)
  else
  begin
    errors++;
    $display("Mismatch retire_valid/insn_ready after reset: %h/%h",
             $sampled(retire_valid), $sampled(insn_ready));
  end

  first_ip_a: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid && retired == 0 |-> retire.ip == 16'h0000)
  else
  begin
    errors++;
    $display("Mismatch first retire.ip: got %h expected 0000", $sampled(retire.ip));
  end

  ip_a: assert property (field_ok(retire.ip, exp_cur.ip))
  else
  begin
    errors++;
    $display("Mismatch retire.ip: got %h expected %h", $sampled(retire.ip),
             $sampled(exp_cur.ip));
  end

  stk0_a: assert property (field_ok(retire.stk0, exp_cur.stk0))
  else
  begin
    errors++;
    $display("Mismatch retire.stk0: got %h expected %h", $sampled(retire.stk0),
             $sampled(exp_cur.stk0));
  end

  fp_a: assert property (field_ok(retire.fp, exp_cur.fp))
  else
  begin
    errors++;
    $display("Mismatch retire.fp: got %h expected %h", $sampled(retire.fp),
             $sampled(exp_cur.fp));
  end

  redirect_a: assert property (field_ok(16'(retire.redirect), 16'(exp_cur.redirect)))
  else
  begin
    errors++;
    $display("Mismatch retire.redirect: got %h expected %h", $sampled(retire.redirect),
             $sampled(exp_cur.redirect));
  end

  target_a: assert property (field_ok(retire.target, exp_cur.target))
  else
  begin
    errors++;
    $display("Mismatch retire.target: got %h expected %h", $sampled(retire.target),
             $sampled(exp_cur.target));
  end

  hold_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid && !retire_ready |=> retire_valid)
  else
  begin
    errors++;
    $display("retire_valid dropped while the record was stalled");
  end

  hold_data_a: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid && !retire_ready |=> retire == last_retire)
  else
  begin
    errors++;
    $display("Mismatch retire: got %h expected %h", $sampled(retire),
             $sampled(last_retire));
  end

  initial
  begin
    logic ok;
    int   waited;
    clk          = 1'b0;
    rst_n        = 1'b0;
    insn_valid   = 1'b0;
    insn         = 16'h0000;
    retire_ready = 1'b0;
    build_program();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    ok = 1'b1;
    for (int i = 0; i < n_prog && ok; i++)
      send_insn(prog[i], ok);
    insn_valid <= 1'b0;
    if (!ok)
    begin
      errors++;
      $display("Timed out waiting for insn_ready");
    end
    waited = 0;
    while (retired < n_prog && waited < TIMEOUT)
    begin
      @(posedge clk);
      waited++;
    end
    if (retired != n_prog)
    begin
      errors++;
      $display("Timed out waiting for retirements, %0d of %0d seen", retired, n_prog);
    end
    $display("Retired %0d of %0d instructions, %0d errors", retired, n_prog, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: stack_core.f
src/stack_core_pkg.sv
src/insn_buffer.sv
src/decoder.sv
src/alu.sv
src/lifo_stack.sv
src/execute_stage.sv
src/stack_core.sv
verification/stack_core_tb.sv

// File: Bender.yml
package:
  name: stack_core

sources:
  - src/stack_core_pkg.sv
  - src/insn_buffer.sv
  - src/decoder.sv
  - src/alu.sv
  - src/lifo_stack.sv
  - src/execute_stage.sv
  - src/stack_core.sv
  - target: test
    files:
      - verification/stack_core_tb.sv
